// ==== src/sprite_macros.svh ====
// frame sizes are a reduced test raster with no sync timing; keep H_TOTAL and V_TOTAL below 256
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// full frame in clocks per line and lines per frame
`define H_TOTAL 40
`define V_TOTAL 30

// visible region starts at screen origin
`define H_ACTIVE 32
`define V_ACTIVE 24

// game area origin in screen coordinates
`define GAME_START_X 4
`define GAME_START_Y 2

// sprite tile size in pixels
`define TILE_W 8
`define TILE_H 8

// number of sprite attribute slots
`define SPRITE_NUM 16

// number of stored tile patterns
`define TILE_NUM 64

// colour shown where no sprite pixel is hit
`define BG_COLOR 12'h214

`endif

// ==== src/spritePkg.sv ====
// shared types only; palette colours are fixed and there is no transparent colour index
package spritePkg;

    // screen or game coordinate
    typedef logic [7:0] posT;
    // 4 bits each of red, green, blue
    typedef logic [11:0] rgbT;
    typedef logic [3:0] spriteIdxT;
    typedef logic [5:0] tileIdxT;
    // high plane in [127:64], low plane in [63:0]
    typedef logic [127:0] tileDataT;

    // one sprite attribute word with msb first
    typedef struct packed {
        posT        posX;
        posT        posY;
        logic [1:0] spare0;
        tileIdxT    tileIndex;
        logic       hFlip;
        logic       vFlip;
        logic [1:0] palette;
        logic [3:0] spare1;
    } spriteEntryT;

    // output pixel of the engine
    typedef struct packed {
        logic valid;
        posT  x;
        posT  y;
        logic inScan;
        rgbT  rgb;
    } pixelT;

    // indexed by palette then by {high bit, low bit}
    localparam rgbT paletteTable [0:3][0:3] = '{
        '{12'h000, 12'hF00, 12'h0F0, 12'h00F},
        '{12'h111, 12'hFF0, 12'h0FF, 12'hF0F},
        '{12'h888, 12'hF80, 12'h08F, 12'h8F0},
        '{12'hFFF, 12'h804, 12'h480, 12'h048}
    };

endpackage

// ==== src/rasterTimer.sv ====
// free-running sweep from reset; active is combinational from the counters, no sync outputs
`timescale 1ns/1ps
`include "sprite_macros.svh"

module rasterTimer (
    input  logic           clk,
    input  logic           rstn,
    output spritePkg::posT posX,
    output spritePkg::posT posY,
    output logic           active
);
    import spritePkg::*;

    logic lineEnd;
    logic frameEnd;

    // last clock of a line and last line of a frame
    assign lineEnd  = (posX == posT'(`H_TOTAL - 1));
    assign frameEnd = (posY == posT'(`V_TOTAL - 1));

    // horizontal counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            posX <= '0;
        end else if (lineEnd) begin
            posX <= '0;
        end else begin
            posX <= posX + 8'd1;
        end
    end

    // vertical counter steps at end of each line
    always_ff @(posedge clk) begin
        if (!rstn) begin
            posY <= '0;
        end else if (lineEnd) begin
            if (frameEnd) begin
                posY <= '0;
            end else begin
                posY <= posY + 8'd1;
            end
        end
    end

    // visible region test
    assign active = (posX < posT'(`H_ACTIVE)) && (posY < posT'(`V_ACTIVE));

endmodule

// ==== src/spriteViewRam.sv ====
// no reset on contents; entries are undefined until the host writes them
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteViewRam (
    input  logic                   clk,
    input  logic                   we,
    input  spritePkg::spriteIdxT   wrAddr,
    input  spritePkg::spriteEntryT wrData,
    input  spritePkg::spriteIdxT   rdAddr,
    output spritePkg::spriteEntryT rdData
);
    import spritePkg::*;

    // attribute array, one word per sprite slot
    spriteEntryT mem [`SPRITE_NUM];

    // host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
    end

    // combinational read for the drawer
    assign rdData = mem[rdAddr];

endmodule

// ==== src/tileRam.sv ====
// no reset and no init file; tiles must be written before they are drawn
`timescale 1ns/1ps
`include "sprite_macros.svh"

module tileRam (
    input  logic                clk,
    input  logic                we,
    input  spritePkg::tileIdxT  wrAddr,
    input  spritePkg::tileDataT wrData,
    input  spritePkg::tileIdxT  rdAddr,
    output spritePkg::tileDataT rdData
);
    import spritePkg::*;

    // one full two-plane pattern per entry
    tileDataT mem [`TILE_NUM];

    // host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
    end

    // combinational pattern read
    assign rdData = mem[rdAddr];

endmodule

// ==== src/tileDraw.sv ====
// single sprite only, fixed 2-cycle latency, RAM reads are combinational and not held across writes
`timescale 1ns/1ps
`include "sprite_macros.svh"

module tileDraw (
    input  logic                   clk,
    input  logic                   rstn,
    input  spritePkg::posT         posX,
    input  spritePkg::posT         posY,
    input  logic                   active,
    input  spritePkg::spriteIdxT   spriteSel,
    output spritePkg::spriteIdxT   entryAddr,
    input  spritePkg::spriteEntryT entry,
    output spritePkg::tileIdxT     tileAddr,
    input  spritePkg::tileDataT    tileData,
    output spritePkg::pixelT       pixel
);
    import spritePkg::*;

    posT        gameX;
    posT        gameY;
    logic [8:0] boxEndX;
    logic [8:0] boxEndY;
    logic       inX;
    logic       inY;
    posT        offX;
    posT        offY;
    logic [2:0] dx;
    logic [2:0] dy;

    // stage 1 registers
    logic       s1Valid;
    logic       s1Hit;
    logic [2:0] s1Dx;
    logic [2:0] s1Dy;
    tileIdxT    s1Tile;
    logic [1:0] s1Pal;
    posT        s1X;
    posT        s1Y;

    logic [5:0] bitNum;
    logic [63:0] planeHi;
    logic [63:0] planeLo;
    logic [1:0] colorIdx;
    rgbT        rgbNext;

    // selected slot goes straight to the view RAM
    assign entryAddr = spriteSel;

    // screen to game coordinates
    assign gameX = posX - posT'(`GAME_START_X);
    assign gameY = posY - posT'(`GAME_START_Y);

    // box ends in 9 bits so a sprite near 255 does not wrap
    assign boxEndX = {1'b0, entry.posX} + 9'(`TILE_W);
    assign boxEndY = {1'b0, entry.posY} + 9'(`TILE_H);

    // screen positions left of or above the game origin never hit
    assign inX = (posX >= posT'(`GAME_START_X)) && (gameX >= entry.posX)
                 && ({1'b0, gameX} < boxEndX);
    assign inY = (posY >= posT'(`GAME_START_Y)) && (gameY >= entry.posY)
                 && ({1'b0, gameY} < boxEndY);

    // offset inside the box
    assign offX = gameX - entry.posX;
    assign offY = gameY - entry.posY;

    // 7 minus a 3-bit offset is its inverse
    assign dx = entry.hFlip ? ~offX[2:0] : offX[2:0];
    assign dy = entry.vFlip ? ~offY[2:0] : offY[2:0];

    // control part of stage 1
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1Valid <= 1'b0;
            s1Hit   <= 1'b0;
        end else begin
            s1Valid <= active;
            s1Hit   <= active && inX && inY;
        end
    end

    // payload part of stage 1
    always_ff @(posedge clk) begin
        s1Dx   <= dx;
        s1Dy   <= dy;
        s1Tile <= entry.tileIndex;
        s1Pal  <= entry.palette;
        s1X    <= posX;
        s1Y    <= posY;
    end

    // pattern fetch uses the registered tile number
    assign tileAddr = s1Tile;

    // pixel number dx + 8*dy
    assign bitNum  = {s1Dy, s1Dx};
    assign planeHi = tileData[127:64];
    assign planeLo = tileData[63:0];

    // bits counted from the top of each plane
    assign colorIdx = {planeHi[~bitNum], planeLo[~bitNum]};

    // palette colour, background, or blank
    always_comb begin
        if (!s1Valid) begin
            rgbNext = '0;
        end else if (s1Hit) begin
            rgbNext = paletteTable[s1Pal][colorIdx];
        end else begin
            rgbNext = `BG_COLOR;
        end
    end

    // stage 2 output register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pixel <= '0;
        end else begin
            pixel.valid  <= s1Valid;
            pixel.x      <= s1X;
            pixel.y      <= s1Y;
            pixel.inScan <= s1Hit;
            pixel.rgb    <= rgbNext;
        end
    end

endmodule

// ==== src/spriteEngine.sv ====
// output is an unthrottled stream at one pixel per clock; the RAMs must be loaded before a frame
`timescale 1ns/1ps

module spriteEngine (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   viewWe,
    input  spritePkg::spriteIdxT   viewAddr,
    input  spritePkg::spriteEntryT viewData,
    input  logic                   tileWe,
    input  spritePkg::tileIdxT     tileAddr,
    input  spritePkg::tileDataT    tileData,
    input  spritePkg::spriteIdxT   spriteSel,
    output spritePkg::pixelT       pixel
);
    import spritePkg::*;

    // raster position into the drawer
    posT         posX;
    posT         posY;
    logic        active;

    // drawer side RAM read buses
    spriteIdxT   entryAddr;
    spriteEntryT entry;
    tileIdxT     drawTileAddr;
    tileDataT    drawTileData;

    rasterTimer uTimer (
        .clk    (clk),
        .rstn   (rstn),
        .posX   (posX),
        .posY   (posY),
        .active (active)
    );

    // sprite attributes written by the host and read by the drawer
    spriteViewRam uViewRam (
        .clk    (clk),
        .we     (viewWe),
        .wrAddr (viewAddr),
        .wrData (viewData),
        .rdAddr (entryAddr),
        .rdData (entry)
    );

    // tile patterns
    tileRam uTileRam (
        .clk    (clk),
        .we     (tileWe),
        .wrAddr (tileAddr),
        .wrData (tileData),
        .rdAddr (drawTileAddr),
        .rdData (drawTileData)
    );

    tileDraw uDraw (
        .clk       (clk),
        .rstn      (rstn),
        .posX      (posX),
        .posY      (posY),
        .active    (active),
        .spriteSel (spriteSel),
        .entryAddr (entryAddr),
        .entry     (entry),
        .tileAddr  (drawTileAddr),
        .tileData  (drawTileData),
        .pixel     (pixel)
    );

endmodule

// ==== tb/pixelChecker.sv ====
// samples the pixel stream at the clock edge; expects each test to start in vertical blanking
`timescale 1ns/1ps
`include "sprite_macros.svh"

module pixelChecker (
    input  logic                   clk,
    input  logic                   rstn,
    input  spritePkg::pixelT       pixel,
    input  logic                   start,
    input  logic                   finish,
    input  logic [95:0]            name,
    input  spritePkg::spriteEntryT entry,
    input  spritePkg::tileDataT    pattern,
    output int                     passCount,
    output int                     failCount
);
    import spritePkg::*;

    logic        armed;
    logic [95:0] testName;
    spriteEntryT testEntry;
    tileDataT    testPattern;
    int          pixCount;
    int          errCount;
    int          errKind;
    int          nextX;
    int          nextY;
    // first mismatch as {inScan, rgb}
    logic [12:0] errExp;
    logic [12:0] errAct;
    int          errX;
    int          errY;
    // raster position expected at the first order mismatch
    int          errExpX;
    int          errExpY;
    logic [12:0] expPix;

    // {inScan, rgb} for a valid pixel at screen (x, y)
    function automatic logic [12:0] modelPixel(input int x, input int y,
                                               input spriteEntryT e, input tileDataT pat);
        int         gx;
        int         gy;
        int         px;
        int         py;
        int         dx;
        int         dy;
        int         p;
        logic [1:0] code;
        px = e.posX;
        py = e.posY;
        // signed game coordinates go negative before the game origin
        gx = x - `GAME_START_X;
        gy = y - `GAME_START_Y;
        if (gx < px || gx >= px + `TILE_W || gy < py || gy >= py + `TILE_H) begin
            return {1'b0, 12'(`BG_COLOR)};
        end
        dx = e.hFlip ? 7 - (gx - px) : gx - px;
        dy = e.vFlip ? 7 - (gy - py) : gy - py;
        // pixel number counted from the top bit of each plane
        p = dx + 8 * dy;
        code = {pat[127 - p], pat[63 - p]};
        return {1'b1, paletteTable[e.palette][code]};
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            armed     = 1'b0;
            passCount = 0;
            failCount = 0;
        end else if (start) begin
            // latch the row for the coming frame
            testName    = name;
            testEntry   = entry;
            testPattern = pattern;
            armed       = 1'b1;
            pixCount    = 0;
            errCount    = 0;
            errKind     = 0;
            nextX       = 0;
            nextY       = 0;
        end else if (armed) begin
            if (pixel.valid) begin
                expPix = modelPixel(nextX, nextY, testEntry, testPattern);
                // raster order follows from the fixed latency
                if (pixel.x !== posT'(nextX) || pixel.y !== posT'(nextY)) begin
                    if (errCount == 0) begin
                        errKind = 2;
                        errExpX = nextX;
                        errExpY = nextY;
                        errX    = pixel.x;
                        errY    = pixel.y;
                    end
                    errCount++;
                end else if ({pixel.inScan, pixel.rgb} !== expPix) begin
                    if (errCount == 0) begin
                        errKind = 1;
                        errExp  = expPix;
                        errAct  = {pixel.inScan, pixel.rgb};
                        errX    = nextX;
                        errY    = nextY;
                    end
                    errCount++;
                end
                pixCount++;
                nextX++;
                if (nextX == `H_ACTIVE) begin
                    nextX = 0;
                    nextY++;
                end
            end else if (pixel.rgb !== 12'h000 || pixel.inScan !== 1'b0) begin
                // blanked pixel must be black and outside the sprite
                if (errCount == 0) begin
                    errKind = 1;
                    errExp  = '0;
                    errAct  = {pixel.inScan, pixel.rgb};
                    errX    = pixel.x;
                    errY    = pixel.y;
                end
                errCount++;
            end
            if (finish) begin
                if (errCount == 0 && pixCount != `H_ACTIVE * `V_ACTIVE) begin
                    errKind = 3;
                end
                case (errKind)
                    0: $display("PASS %0s", testName);
                    1: begin
                        $write("FAIL %0s expected rgb %h inScan %b ", testName, errExp[11:0],
                               errExp[12]);
                        $display("actual rgb %h inScan %b at (%0d,%0d)", errAct[11:0],
                                 errAct[12], errX, errY);
                    end
                    2: $display("FAIL %0s expected pixel (%0d,%0d) actual pixel (%0d,%0d)",
                                testName, errExpX, errExpY, errX, errY);
                    default: $display("FAIL %0s expected %0d active pixels actual %0d",
                                      testName, `H_ACTIVE * `V_ACTIVE, pixCount);
                endcase
                if (errKind == 0) begin
                    passCount++;
                end else begin
                    failCount++;
                end
                armed = 1'b0;
            end
        end
    end

endmodule

// ==== tb/spriteEngine_asserts.sv ====
// output sanity only; pixel values are checked against the model elsewhere
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteEngineAsserts (
    input logic             clk,
    input logic             rstn,
    input spritePkg::pixelT pixel
);
    import spritePkg::*;

    // valid only inside the visible region
    validInActive: assert property (@(posedge clk) disable iff (!rstn)
        pixel.valid |-> (pixel.x < posT'(`H_ACTIVE)) && (pixel.y < posT'(`V_ACTIVE)))
        else $error("valid pixel outside the active area");

    // a sprite hit is always a visible pixel
    scanNeedsValid: assert property (@(posedge clk) disable iff (!rstn)
        pixel.inScan |-> pixel.valid)
        else $error("inScan set on a blanked pixel");

    // blanking is black
    blankIsBlack: assert property (@(posedge clk) disable iff (!rstn)
        !pixel.valid |-> (pixel.rgb == 12'h000))
        else $error("blanked pixel carries a colour");

endmodule

bind spriteEngine spriteEngineAsserts uAsserts (
    .clk   (clk),
    .rstn  (rstn),
    .pixel (pixel)
);

// ==== tb/spriteEngineTb.sv ====
// one table row per frame, RAMs loaded in vertical blanking; run length bounded by a watchdog
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteEngineTb;
    import spritePkg::*;

    localparam int NUM_TESTS  = 11;
    localparam int FRAME_NS   = `H_TOTAL * `V_TOTAL * 8;
    localparam int TIMEOUT_NS = (NUM_TESTS + 2) * FRAME_NS + 8 * 8;
    // asymmetric in both axes and holds all four codes
    localparam tileDataT PAT_A = {64'hFEC8_8000_0103_070F, 64'hA5F0_0C33_8001_60E2};

    typedef struct packed {
        logic [95:0] name;
        spriteIdxT   slot;
        spriteEntryT entry;
        tileIdxT     tile;
        tileDataT    pattern;
    } testRowT;

    logic        clk;
    logic        rstn;
    logic        viewWe;
    spriteIdxT   viewAddr;
    spriteEntryT viewData;
    logic        tileWe;
    tileIdxT     tileAddr;
    tileDataT    tileData;
    spriteIdxT   spriteSel;
    pixelT       pixel;
    logic        start;
    logic        finish;
    testRowT     cur;
    int          passCount;
    int          failCount;
    testRowT     rows [NUM_TESTS];
    tileDataT    randPat [2];
    logic [31:0] lfsr;

    spriteEngine UUT (
        .clk       (clk),
        .rstn      (rstn),
        .viewWe    (viewWe),
        .viewAddr  (viewAddr),
        .viewData  (viewData),
        .tileWe    (tileWe),
        .tileAddr  (tileAddr),
        .tileData  (tileData),
        .spriteSel (spriteSel),
        .pixel     (pixel)
    );

    pixelChecker uChecker (
        .clk       (clk),
        .rstn      (rstn),
        .pixel     (pixel),
        .start     (start),
        .finish    (finish),
        .name      (cur.name),
        .entry     (cur.entry),
        .pattern   (cur.pattern),
        .passCount (passCount),
        .failCount (failCount)
    );

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic testRowT makeRow(input logic [95:0] name, input spriteIdxT slot,
                                        input posT x, input posT y, input tileIdxT tile,
                                        input logic hf, input logic vf, input logic [1:0] pal,
                                        input tileDataT pat);
        testRowT r;
        r.name    = name;
        r.slot    = slot;
        r.entry   = '{posX: x, posY: y, spare0: 2'b00, tileIndex: tile, hFlip: hf,
                      vFlip: vf, palette: pal, spare1: 4'h0};
        r.tile    = tile;
        r.pattern = pat;
        return r;
    endfunction

    // returns 1 ns after the edge that shows the last visible output pixel
    task automatic waitFrameEnd();
        do begin
            @(posedge clk);
        end while (!(pixel.valid && pixel.x == posT'(`H_ACTIVE - 1)
                     && pixel.y == posT'(`V_ACTIVE - 1)));
        #1;
    endtask

    // one-cycle write of entry and tile plus the checker event
    task automatic loadRow(input testRowT r);
        viewWe    = 1'b1;
        viewAddr  = r.slot;
        viewData  = r.entry;
        tileWe    = 1'b1;
        tileAddr  = r.tile;
        tileData  = r.pattern;
        spriteSel = r.slot;
        cur       = r;
        start     = 1'b1;
        @(posedge clk);
        #1;
        viewWe = 1'b0;
        tileWe = 1'b0;
        start  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("simulation timed out waiting for tests");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rstn      = 1'b0;
        viewWe    = 1'b0;
        viewAddr  = '0;
        viewData  = '0;
        tileWe    = 1'b0;
        tileAddr  = '0;
        tileData  = '0;
        spriteSel = '0;
        start     = 1'b0;
        finish    = 1'b0;
        cur       = '0;
        // random patterns with one lfsr step per bit
        lfsr = 32'hd8cb;
        for (int i = 0; i < 2; i++) begin
            for (int b = 0; b < 128; b++) begin
                lfsr = lfsrStep(lfsr);
                randPat[i][b] = lfsr[0];
            end
        end
        // name, slot, x, y, tile, hFlip, vFlip, palette, pattern
        rows[0]  = makeRow("plain_pal0", 4'd0, 8'd10, 8'd6, 6'd1, 1'b0, 1'b0, 2'd0, PAT_A);
        rows[1]  = makeRow("hflip", 4'd1, 8'd3, 8'd9, 6'd2, 1'b1, 1'b0, 2'd0, PAT_A);
        rows[2]  = makeRow("vflip", 4'd2, 8'd12, 8'd4, 6'd3, 1'b0, 1'b1, 2'd0, PAT_A);
        rows[3]  = makeRow("hvflip", 4'd3, 8'd17, 8'd11, 6'd4, 1'b1, 1'b1, 2'd0, PAT_A);
        rows[4]  = makeRow("palette1", 4'd4, 8'd5, 8'd5, 6'd5, 1'b0, 1'b0, 2'd1, PAT_A);
        rows[5]  = makeRow("palette2", 4'd5, 8'd6, 8'd7, 6'd6, 1'b0, 1'b0, 2'd2, PAT_A);
        rows[6]  = makeRow("palette3", 4'd6, 8'd7, 8'd8, 6'd7, 1'b0, 1'b0, 2'd3, PAT_A);
        // box runs past the right and bottom of the visible area
        rows[7]  = makeRow("clip_corner", 4'd7, 8'd24, 8'd18, 6'd8, 1'b1, 1'b0, 2'd1, PAT_A);
        // box wraps over the game origin so only screen x<4 and y<2 could match
        rows[8]  = makeRow("pre_origin", 4'd8, 8'd250, 8'd254, 6'd9, 1'b0, 1'b0, 2'd2, PAT_A);
        rows[9]  = makeRow("rand_a", 4'd9, 8'd0, 8'd0, 6'd40, 1'b0, 1'b1, 2'd2, randPat[0]);
        // slot 0 rewritten with another tile
        rows[10] = makeRow("rand_b", 4'd0, 8'd20, 8'd13, 6'd63, 1'b1, 1'b0, 2'd3, randPat[1]);

        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        waitFrameEnd();
        for (int i = 0; i < NUM_TESTS; i++) begin
            loadRow(rows[i]);
            waitFrameEnd();
            finish = 1'b1;
            @(posedge clk);
            #1;
            finish = 1'b0;
        end

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && passCount == NUM_TESTS) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/spritePkg.sv
src/rasterTimer.sv
src/spriteViewRam.sv
src/tileRam.sv
src/tileDraw.sv
src/spriteEngine.sv
tb/pixelChecker.sv
tb/spriteEngine_asserts.sv
tb/spriteEngineTb.sv

// ==== Bender.yml ====
package:
  name: sprite_engine

sources:
  - include_dirs:
      - src
    files:
      - src/spritePkg.sv
      - src/rasterTimer.sv
      - src/spriteViewRam.sv
      - src/tileRam.sv
      - src/tileDraw.sv
      - src/spriteEngine.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/pixelChecker.sv
      - tb/spriteEngine_asserts.sv
      - tb/spriteEngineTb.sv
